// ==== sim.f ====
mem_pkg.sv
load_pkg.sv
rom_load_counter.sv
rom_port.sv
rv_word_bridge.sv
snes_mem_front.sv
tb_snes_mem_front.sv

// ==== Bender.yml ====
package:
  name: snes_mem_front

sources:
  # Packages first, then the design bottom up
  - mem_pkg.sv
  - load_pkg.sv
  - rom_load_counter.sv
  - rom_port.sv
  - rv_word_bridge.sv
  - snes_mem_front.sv
  - target: simulation
    files:
      - tb_snes_mem_front.sv

// ==== tb_snes_mem_front.sv ====
/*
 * Directed testbench for the memory request front end
 *   - clock, reset and a behavioural SDRAM word model for both channels
 *   - compare task and bounded wait helpers
 *   - tests for reset state, cartridge load, ROM reads and host accesses
 */
module tb_snes_mem_front
    import mem_pkg::*;
    import load_pkg::*;
();

    localparam int DRIVE_DLY = 10;
    localparam int TIMEOUT   = 200;

    logic mclk;
    logic resetn;
    logic loading;
    logic [7:0] load_byte;
    logic load_valid;
    logic header_done;
    logic sdram_busy;
    logic run_enable;
    rom_addr_t rom_addr;
    logic rom_ce_n;
    logic rom_word;
    word_t rom_q;
    sd_word_req_t cpu_word;
    logic cpu_req;
    word_t cpu_dout = '0;
    logic rv_valid;
    rv_bus_req_t rv_bus;
    logic rv_ready;
    rv_data_t rv_rdata;
    sd_word_req_t rv_word;
    logic rv_req;
    logic rv_ack = 1'b0;
    word_t rv_dout = '0;

    // 4K model words cover all test addresses
    word_t mem [0:4095];
    logic cpu_seen;
    logic cpu_ack;
    logic rv_seen;
    int cpu_cnt;
    int rv_cnt;
    word_t cpu_rd;
    word_t rv_rd;

    int errors = 0;
    int i;
    int k;
    logic [31:0] rnd;
    logic [7:0] image [$];

    snes_mem_front dut (.*);

    initial begin
        mclk = 1'b0;
        forever #50 mclk = ~mclk;
    end

    function automatic word_t fill_word(input logic [11:0] a);
        return {a[3:0], a} ^ 16'hc35a;
    endfunction

    task automatic mem_write(input sd_word_req_t r);
        if (r.ds[0]) mem[r.addr[11:0]][7:0] = r.din[7:0];
        if (r.ds[1]) mem[r.addr[11:0]][15:8] = r.din[15:8];
    endtask

    // CPU channel ack goes only to the testbench
    always @(posedge mclk) begin
        if (!resetn) begin
            cpu_seen <= 1'b0;
            cpu_ack  <= 1'b0;
            cpu_cnt  <= 0;
        end else if (cpu_req != cpu_seen) begin
            cpu_seen <= cpu_req;
            if (cpu_word.we)
                mem_write(cpu_word);
            cpu_rd  <= mem[cpu_word.addr[11:0]];
            cpu_cnt <= 1 + $urandom % 4;      // Ack after 1 to 4 cycles
        end else if (cpu_cnt != 0) begin
            cpu_cnt <= cpu_cnt - 1;
            if (cpu_cnt == 1) begin
                cpu_ack  <= cpu_seen;
                cpu_dout <= cpu_rd;
            end
        end
    end

    // Host channel
    always @(posedge mclk) begin
        if (!resetn) begin
            rv_seen <= 1'b0;
            rv_ack  <= 1'b0;
            rv_cnt  <= 0;
        end else if (rv_req != rv_seen) begin
            rv_seen <= rv_req;
            if (rv_word.we)
                mem_write(rv_word);
            rv_rd  <= mem[rv_word.addr[11:0]];
            rv_cnt <= 1 + $urandom % 4;
        end else if (rv_cnt != 0) begin
            rv_cnt <= rv_cnt - 1;
            if (rv_cnt == 1) begin
                rv_ack  <= rv_seen;
                rv_dout <= rv_rd;
            end
        end
    end

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("Checks failed");
        $fatal(1);
    endtask

    // All stimulus changes a little after the rising edge
    task automatic step();
        @(posedge mclk);
        #DRIVE_DLY;
    endtask

    task automatic wait_cpu_ack();
        int n;
        for (n = 0; cpu_ack != cpu_req && n < TIMEOUT; n++) step();
        if (cpu_ack != cpu_req) fail_timeout("CPU channel ack");
    endtask

    task automatic wait_ready();
        int n;
        step();
        for (n = 0; !rv_ready && n < TIMEOUT; n++) step();
        if (!rv_ready) fail_timeout("host ready");
    endtask

    task automatic send_byte(input logic [7:0] b);
        load_byte  = b;
        load_valid = 1'b1;
        step();
        load_valid = 1'b0;
        step();
    endtask

    task automatic check_reset_state();
        check_eq("rv_ready after reset", rv_ready, 0);
        check_eq("run_enable after reset", run_enable, 0);
        check_eq("cpu_req after reset", cpu_req, 0);
        check_eq("rv_req after reset", rv_req, 0);
    endtask

    task automatic load_image(input int n);
        int j;
        logic [7:0] b;
        loading = 1'b1;
        step();
        for (j = 0; j < HEADER_BYTES; j++) send_byte($urandom);
        check_eq("header_done", header_done, 1);
        for (j = 0; j < n; j++) begin
            b = $urandom;
            image.push_back(b);
            send_byte(b);
        end
        sdram_busy = 1'b1;
        loading    = 1'b0;
        step();
        wait_cpu_ack();
        for (j = 0; j < n / 2; j++)
            check_eq("loaded word", mem[j], {image[2*j+1], image[2*j]});
        repeat (6) begin
            step();
            check_eq("run_enable while busy", run_enable, 0);
        end
        sdram_busy = 1'b0;
        for (j = 0; !run_enable && j < TIMEOUT; j++) step();
        if (!run_enable) fail_timeout("run_enable");
    endtask

    task automatic rom_read_check(input rom_addr_t a, input logic wd, input word_t exp);
        logic old;
        int n;
        old      = cpu_req;
        rom_addr = a;
        rom_word = wd;
        rom_ce_n = 1'b0;
        for (n = 0; cpu_req == old && n < TIMEOUT; n++) step();
        if (cpu_req == old) fail_timeout("ROM read request");
        wait_cpu_ack();
        check_eq("rom_q", rom_q, exp);
    endtask

    task automatic host_access(input logic [22:0] a, input rv_data_t d, input rv_strb_t s,
                               output rv_data_t rdata);
        rv_bus.addr  = a;
        rv_bus.wdata = d;
        rv_bus.wstrb = s;
        rv_valid     = 1'b1;
        wait_ready();
        rdata    = rv_rdata;
        rv_valid = 1'b0;
        step();
    endtask

    function automatic rv_data_t merge(input rv_data_t old, input rv_data_t d, input rv_strb_t s);
        rv_data_t r;
        r = old;
        for (int b = 0; b < 4; b++)
            if (s[b]) r[8*b +: 8] = d[8*b +: 8];
        return r;
    endfunction

    task automatic host_tests();
        rv_strb_t strobes [4];
        rv_data_t rd;
        rv_data_t wd;
        rv_data_t exp;
        strobes = '{4'hf, 4'h3, 4'hc, 4'h5};
        // Plain read of two preloaded words
        mem[12'h800] = $urandom;
        mem[12'h801] = $urandom;
        host_access(23'h001000, '0, 4'h0, rd);
        check_eq("host read", rd, {mem[12'h801], mem[12'h800]});
        foreach (strobes[j]) begin
            wd  = $urandom;
            exp = merge({mem[12'h805], mem[12'h804]}, wd, strobes[j]);
            host_access(23'h001008, wd, strobes[j], rd);
            host_access(23'h001008, '0, 4'h0, rd);
            check_eq("host write read-back", rd, exp);
        end
        // Read raised while the write is still in flight
        wd           = $urandom;
        rv_bus.addr  = 23'h001010;
        rv_bus.wdata = wd;
        rv_bus.wstrb = 4'hf;
        rv_valid     = 1'b1;
        step();
        rv_valid = 1'b0;
        step();
        rv_bus.wstrb = 4'h0;
        rv_valid     = 1'b1;
        wait_ready();
        wait_ready();
        check_eq("pending read", rv_rdata, wd);
        rv_valid = 1'b0;
        step();
    endtask

    initial begin
        rnd        = $urandom(32'h5f7);
        resetn     = 1'b0;
        loading    = 1'b0;
        load_byte  = '0;
        load_valid = 1'b0;
        sdram_busy = 1'b0;
        rom_addr   = '0;
        rom_ce_n   = 1'b1;
        rom_word   = 1'b0;
        rv_valid   = 1'b0;
        rv_bus     = '0;
        for (i = 0; i < 4096; i++) mem[i] = fill_word(i);
        repeat (10) @(posedge mclk);
        #DRIVE_DLY resetn = 1'b1;
        step();
        check_reset_state();
        load_image(16);
        // Only odd byte reads swap the bytes
        for (k = 0; k < 8; k++) begin
            rom_read_check(2 * k + 1, k[0], k[0] ? {image[2*k+1], image[2*k]}
                                                 : {image[2*k], image[2*k+1]});
            rom_read_check(2 * k, ~k[0], {image[2*k+1], image[2*k]});
        end
        rom_ce_n = 1'b1;
        host_tests();
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== snes_mem_front.sv ====
/*
 * Memory request front end
 *   - load counter and run gate
 *   - ROM port on the CPU SDRAM channel
 *   - host bus bridge on the host SDRAM channel
 */
module snes_mem_front
    import mem_pkg::*;
    import load_pkg::*;
(
    input  logic         mclk,
    input  logic         resetn,

    // Cartridge loader
    input  logic         loading,
    input  logic [7:0]   load_byte,
    input  logic         load_valid,
    output logic         header_done,

    // Emulator side
    input  logic         sdram_busy,
    output logic         run_enable,
    input  rom_addr_t    rom_addr,
    input  logic         rom_ce_n,
    input  logic         rom_word,
    output word_t        rom_q,

    // CPU SDRAM channel
    output sd_word_req_t cpu_word,
    output logic         cpu_req,
    input  word_t        cpu_dout,

    // Host bus and its SDRAM channel
    input  logic         rv_valid,
    input  rv_bus_req_t  rv_bus,
    output logic         rv_ready,
    output rv_data_t     rv_rdata,
    output sd_word_req_t rv_word,
    output logic         rv_req,
    input  logic         rv_ack,
    input  word_t        rv_dout
);

    rom_addr_t load_addr;
    logic      load_strobe;
    logic      load_start;

    rom_load_counter u_load_counter (
        .mclk        (mclk),
        .resetn      (resetn),
        .loading     (loading),
        .load_valid  (load_valid),
        .sdram_busy  (sdram_busy),
        .header_done (header_done),
        .load_addr   (load_addr),
        .load_strobe (load_strobe),
        .load_start  (load_start),
        .run_enable  (run_enable)
    );

    rom_port u_rom_port (
        .mclk        (mclk),
        .resetn      (resetn),
        .loading     (loading),
        .load_byte   (load_byte),
        .load_strobe (load_strobe),
        .load_addr   (load_addr),
        .load_start  (load_start),
        .rom_addr    (rom_addr),
        .rom_ce_n    (rom_ce_n),
        .rom_word    (rom_word),
        .rom_q       (rom_q),
        .cpu_word    (cpu_word),
        .cpu_req     (cpu_req),
        .cpu_dout    (cpu_dout)
    );

    rv_word_bridge u_rv_bridge (
        .mclk     (mclk),
        .resetn   (resetn),
        .rv_valid (rv_valid),
        .rv_bus   (rv_bus),
        .rv_ready (rv_ready),
        .rv_rdata (rv_rdata),
        .rv_word  (rv_word),
        .rv_req   (rv_req),
        .rv_ack   (rv_ack),
        .rv_dout  (rv_dout)
    );

endmodule

// ==== rv_word_bridge.sv ====
/*
 * Host bus to SDRAM word bridge
 *   - splits 32-bit host accesses into two 16-bit channel requests
 *   - skips a write half whose strobes are all zero
 *   - remembers a host request that arrives while busy
 */
module rv_word_bridge
    import mem_pkg::*;
(
    input  logic         mclk,
    input  logic         resetn,
    input  logic         rv_valid,
    input  rv_bus_req_t  rv_bus,
    output logic         rv_ready,
    output rv_data_t     rv_rdata,
    output sd_word_req_t rv_word,
    output logic         rv_req,
    input  logic         rv_ack,
    input  word_t        rv_dout
);

    rv_state_e    state;
    logic         rv_valid_r;
    logic         new_req;
    logic         pend;
    logic         start;
    logic         cur_write;
    rv_bus_req_t  cur;
    word_t        dout0;

    // Payload for one half of a host access
    function automatic sd_word_req_t half_req(rv_bus_req_t b, logic hi, byte_sel_t ds);
        sd_word_req_t r;
        r.addr = {b.addr[22:2], hi};
        r.din  = hi ? b.wdata[31:16] : b.wdata[15:0];
        r.ds   = ds;
        r.we   = |b.wstrb;
        return r;
    endfunction

    assign new_req   = rv_valid & ~rv_valid_r;
    assign start     = (state == RV_IDLE_REQ0) & (pend | new_req);
    assign cur_write = |cur.wstrb;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            state      <= RV_IDLE_REQ0;
            rv_valid_r <= 1'b0;
            pend       <= 1'b0;
            rv_req     <= 1'b0;
            rv_ready   <= 1'b0;
        end else begin
            rv_valid_r <= rv_valid;
            rv_ready   <= 1'b0;
            if (start)
                pend <= 1'b0;
            else if (new_req)
                pend <= 1'b1;            // Served once the current access ends

            case (state)
                RV_IDLE_REQ0: if (start) begin
                    rv_req <= ~rv_req;
                    if (|rv_bus.wstrb && rv_bus.wstrb[1:0] == 2'b00)
                        state <= RV_WAIT1;           // Upper half write only
                    else
                        state <= RV_WAIT0_REQ1;
                end
                RV_WAIT0_REQ1: if (rv_req == rv_ack) begin
                    if (!cur_write) begin
                        state <= RV_DATA0;
                    end else if (cur.wstrb[3:2] == 2'b00) begin
                        rv_ready <= 1'b1;            // Lower half write only
                        state    <= RV_IDLE_REQ0;
                    end else begin
                        rv_req <= ~rv_req;
                        state  <= RV_WAIT1;
                    end
                end
                RV_DATA0: begin
                    rv_req <= ~rv_req;       // Upper word read
                    state  <= RV_WAIT1;
                end
                RV_WAIT1: if (rv_req == rv_ack) begin
                    if (cur_write) begin
                        rv_ready <= 1'b1;
                        state    <= RV_IDLE_REQ0;
                    end else begin
                        state <= RV_DATA1;
                    end
                end
                RV_DATA1: begin
                    rv_ready <= 1'b1;
                    state    <= RV_IDLE_REQ0;
                end
                default: state <= RV_IDLE_REQ0;
            endcase
        end
    end

    // Access payload and read data
    always_ff @(posedge mclk) begin
        if (start) begin
            cur <= rv_bus;
            if (|rv_bus.wstrb && rv_bus.wstrb[1:0] == 2'b00)
                rv_word <= half_req(rv_bus, 1'b1, rv_bus.wstrb[3:2]);
            else if (|rv_bus.wstrb)
                rv_word <= half_req(rv_bus, 1'b0, rv_bus.wstrb[1:0]);
            else
                rv_word <= half_req(rv_bus, 1'b0, 2'b11);
        end else if (state == RV_WAIT0_REQ1 && rv_req == rv_ack && cur_write &&
                     cur.wstrb[3:2] != 2'b00) begin
            rv_word <= half_req(cur, 1'b1, cur.wstrb[3:2]);
        end else if (state == RV_DATA0) begin
            dout0   <= rv_dout;
            rv_word <= half_req(cur, 1'b1, 2'b11);
        end
        if (state == RV_DATA1)
            rv_rdata <= {rv_dout, dout0};    // Upper word above lower
    end

endmodule

// ==== rom_port.sv ====
/*
 * ROM port on the CPU SDRAM channel
 *   - pairs load bytes into 16-bit write requests
 *   - issues ROM reads when the emulator address changes
 *   - byte order selection for odd byte reads
 */
module rom_port
    import mem_pkg::*;
    import load_pkg::*;
(
    input  logic         mclk,
    input  logic         resetn,
    input  logic         loading,
    input  logic [7:0]   load_byte,
    input  logic         load_strobe,
    input  rom_addr_t    load_addr,
    input  logic         load_start,
    input  rom_addr_t    rom_addr,
    input  logic         rom_ce_n,
    input  logic         rom_word,
    output word_t        rom_q,
    output sd_word_req_t cpu_word,
    output logic         cpu_req,
    input  word_t        cpu_dout
);

    logic         load_wr;
    logic         rom_rd;
    logic [7:0]   prev_byte;
    rom_addr_t    last_addr;
    logic         last_valid;
    sd_word_req_t word_q;
    logic         req_q;

    // Odd byte completes a pair
    assign load_wr = load_strobe & load_addr[0];

    // New ROM read whenever the emulator moves to another address
    assign rom_rd = ~loading & ~rom_ce_n & (~last_valid | (rom_addr != last_addr));

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            req_q      <= 1'b0;
            last_valid <= 1'b0;
        end else begin
            if (load_wr || rom_rd)
                req_q <= ~req_q;
            if (load_start)
                last_valid <= 1'b0;          // Memory content is about to change
            else if (rom_rd)
                last_valid <= 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (load_strobe)
            prev_byte <= load_byte;

        if (load_wr) begin
            word_q.addr <= load_addr[22:1];
            word_q.din  <= {load_byte, prev_byte};
            word_q.ds   <= 2'b11;
            word_q.we   <= 1'b1;
        end else if (rom_rd) begin
            word_q.addr <= rom_addr[22:1];
            word_q.ds   <= 2'b11;        // Always fetch the full word
            word_q.we   <= 1'b0;
            last_addr   <= rom_addr;
        end
    end

    assign cpu_word = word_q;
    assign cpu_req  = req_q;

    // Odd byte of a byte read goes to the low lane
    assign rom_q = (rom_word || !rom_addr[0]) ? cpu_dout
                                              : {cpu_dout[7:0], cpu_dout[15:8]};

endmodule

// ==== rom_load_counter.sv ====
/*
 * Cartridge load sequencing
 *   - edge detection on the loading flag
 *   - header byte counter and load byte address
 *   - loaded flag and registered run gate for the emulator
 */
module rom_load_counter
    import load_pkg::*;
(
    input  logic      mclk,
    input  logic      resetn,
    input  logic      loading,
    input  logic      load_valid,
    input  logic      sdram_busy,
    output logic      header_done,
    output rom_addr_t load_addr,
    output logic      load_strobe,
    output logic      load_start,
    output logic      run_enable
);

    logic     loading_r;
    logic     load_end;
    logic     loaded;
    logic     hdr_count_en;
    hdr_cnt_t hdr_cnt;

    assign load_start = loading & ~loading_r;
    assign load_end   = ~loading & loading_r;

    assign header_done  = (hdr_cnt == HEADER_BYTES);
    assign hdr_count_en = loading & load_valid & ~header_done;    // Header bytes are dropped
    assign load_strobe  = loading & load_valid & header_done;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            loading_r  <= 1'b0;
            hdr_cnt    <= '0;
            load_addr  <= '0;
            loaded     <= 1'b0;
            run_enable <= 1'b0;
        end else begin
            loading_r <= loading;

            // Emulator only runs on a finished image with SDRAM ready
            run_enable <= loaded & ~sdram_busy & ~loading;

            if (load_start) begin
                hdr_cnt   <= '0;
                load_addr <= '0;
                loaded    <= 1'b0;
            end else begin
                if (hdr_count_en)
                    hdr_cnt <= hdr_cnt + 1'b1;
                if (load_strobe)
                    load_addr <= load_addr + 1'b1;   // Next byte position
                if (load_end)
                    loaded <= 1'b1;
            end
        end
    end

endmodule

// ==== load_pkg.sv ====
/*
 * Cartridge load definitions
 *   - ROM byte address type
 *   - header byte count type
 *   - size of the skipped cartridge header
 */
package load_pkg;

    // Byte address into the ROM area of the SDRAM
    typedef logic [22:0] rom_addr_t;

    // Counts header bytes, wide enough to hold the full header size
    typedef logic [6:0] hdr_cnt_t;

    // Leading bytes of the image that are not stored
    localparam hdr_cnt_t HEADER_BYTES = 7'd64;

endpackage

// ==== mem_pkg.sv ====
/*
 * SDRAM word channel and host bus types
 *   - word, word address and byte enable types
 *   - host bus data and strobe types
 *   - request payload structs for one SDRAM channel and the host bus
 *   - host bridge state encoding
 */
package mem_pkg;

    // SDRAM side
    typedef logic [15:0] word_t;
    typedef logic [21:0] word_addr_t;
    typedef logic [1:0]  byte_sel_t;     // Bit 1 is the upper byte

    // Host processor side
    typedef logic [31:0] rv_data_t;
    typedef logic [3:0]  rv_strb_t;

    // One request on an SDRAM channel, sampled when req flips
    typedef struct packed {
        word_addr_t addr;
        word_t      din;
        byte_sel_t  ds;
        logic       we;
    } sd_word_req_t;

    // Host access, held by the host until ready
    typedef struct packed {
        logic [22:0] addr;              // Byte address
        rv_data_t    wdata;
        rv_strb_t    wstrb;             // All zero for a read
    } rv_bus_req_t;

    // Host bridge states
    typedef enum logic [2:0] {
        RV_IDLE_REQ0,                   // Wait for a host access, issue first word
        RV_WAIT0_REQ1,                  // Wait for first ack
        RV_DATA0,                       // Take lower read word
        RV_WAIT1,                       // Wait for second ack
        RV_DATA1                        // Take upper read word, answer host
    } rv_state_e;

endpackage
